/* Makefile */
# Verilator build for the divide unit testbench.

VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= tb_div_unit
FILELIST  ?= div_unit.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Test completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)

# Pass only when the pass message shows up as a line of its own.
sim: build
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* div_unit.f */
+incdir+testbench
hdl/div_pkg.sv
hdl/div_core_if.sv
hdl/div_subshift.sv
hdl/div_sign_stage.sv
hdl/div_unit_top.sv
testbench/tb_div_unit.sv

/* hdl/div_core_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface div_core_if
  import div_pkg::*;
();

  logic  start;      // Start request toward the core.
  data_t dividend;   // Unsigned dividend magnitude.
  data_t divisor;    // Unsigned divisor magnitude.
  logic  done;       // Core idle.
  data_t quotient;   // Unsigned quotient.
  data_t remainder;  // Unsigned remainder.

  // Sign stage side.
  modport sign_mp (
    output start,
    output dividend,
    output divisor,
    input  done,
    input  quotient,
    input  remainder
  );

  // Divider core side.
  modport core_mp (
    input  start,
    input  dividend,
    input  divisor,
    output done,
    output quotient,
    output remainder
  );

endinterface

`default_nettype wire

/* hdl/div_pkg.sv */
`default_nettype none

package div_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Operand and result width.
  localparam int DATA_W = 32;

  // Counter must reach DATA_W+1, the drain stage.
  localparam int CNT_W = $clog2(DATA_W + 2);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Vector types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Dividend, divisor, quotient or remainder.
  typedef logic [DATA_W-1:0] data_t;

  // Combined register.
  // Top bit is the carry out of the window, then remainder, then quotient.
  typedef logic [2*DATA_W:0] dqr_t;

  // Program counter of the core.
  typedef logic [CNT_W-1:0] cnt_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sequencer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Count at which all quotient bits are in.
  localparam cnt_t LAST_STAGE = cnt_t'(DATA_W + 1);

endpackage

`default_nettype wire

/* hdl/div_sign_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module div_sign_stage
  import div_pkg::*;
(
  input  wire logic   clk_i,
  input  wire logic   cke_i,
  input  wire logic   rst_i,
  input  wire logic   start_i,
  input  wire logic   signed_i,
  input  wire data_t  dividend_i,
  input  wire data_t  divisor_i,
  output data_t       quotient_o,
  output data_t       remainder_o,
  output logic        div_by_zero_o,
  div_core_if.sign_mp core
);

  // Two's complement negate when asked.
  function automatic data_t apply_sign(input data_t value, input logic neg);
    data_t res;
    res = neg ? (~value + data_t'(1)) : value;
    return res;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Operand path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic dividend_sign;  // Raw sign bits.
  logic divisor_sign;
  logic accept;         // Core takes the operands on this edge.
  logic done_prev_q;    // Core done on the previous enabled edge.

  assign dividend_sign = dividend_i[DATA_W-1];
  assign divisor_sign  = divisor_i[DATA_W-1];

  assign core.start    = start_i;
  assign core.dividend = apply_sign(dividend_i, signed_i & dividend_sign);
  assign core.divisor  = apply_sign(divisor_i, signed_i & divisor_sign);

  // Done is also high on the final count, where the core takes no start.
  assign accept = start_i & core.done & done_prev_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      done_prev_q <= 1'b1;
    end else if (cke_i) begin
      done_prev_q <= core.done;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Captured flags
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic  signed_q;    // Operation was signed.
  logic  q_sign_q;    // Operand signs differ.
  logic  r_sign_q;    // Dividend was negative.
  logic  dz_q;        // Divisor was zero.
  data_t dividend_q;  // Original dividend for the zero-divisor case.

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      signed_q <= 1'b0;
      q_sign_q <= 1'b0;
      r_sign_q <= 1'b0;
      dz_q     <= 1'b0;
    end else if (cke_i && accept) begin
      signed_q <= signed_i;
      q_sign_q <= dividend_sign ^ divisor_sign;
      r_sign_q <= dividend_sign;
      dz_q     <= (divisor_i == '0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (cke_i && accept) begin
      dividend_q <= dividend_i;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Result path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  data_t quotient_fix;   // Signed results before the zero check.
  data_t remainder_fix;

  // Quotient truncates toward zero, remainder follows the dividend.
  assign quotient_fix  = apply_sign(core.quotient, signed_q & q_sign_q);
  assign remainder_fix = apply_sign(core.remainder, signed_q & r_sign_q);

  assign quotient_o    = dz_q ? '1 : quotient_fix;            // All ones on zero divisor.
  assign remainder_o   = dz_q ? dividend_q : remainder_fix;   // Dividend passes through.
  assign div_by_zero_o = dz_q;

endmodule

`default_nettype wire

/* hdl/div_subshift.sv */
`timescale 1ns/1ps
`default_nettype none

module div_subshift
  import div_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     cke_i,
  input  wire logic     rst_i,
  div_core_if.core_mp   core
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // State
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  dqr_t  dqr_q;       // Dividend, quotient and remainder.
  dqr_t  dqr_d;
  data_t divisor_q;   // Held divisor.
  data_t divisor_d;
  cnt_t  pcnt_q;      // Program counter.
  cnt_t  pcnt_d;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dqr_q     <= '0;
      divisor_q <= '0;
      pcnt_q    <= '0;
    end else if (cke_i) begin
      dqr_q     <= dqr_d;
      divisor_q <= divisor_d;
      pcnt_q    <= pcnt_d;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Datapath
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  data_t         window;  // Partial remainder with the next dividend bit.
  logic [DATA_W:0] diff;  // Trial difference, top bit is the borrow.

  assign window = dqr_q[2*DATA_W-2 -: DATA_W];
  assign diff   = {1'b0, window} - {1'b0, divisor_q};

  assign core.quotient  = dqr_q[DATA_W-1:0];
  assign core.remainder = dqr_q[2*DATA_W-1:DATA_W];

  // High while idle and on the final count.
  assign core.done = (pcnt_q == '0) || (pcnt_q == LAST_STAGE);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Program
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    pcnt_d    = pcnt_q + cnt_t'(1);
    dqr_d     = dqr_q;
    divisor_d = divisor_q;

    if (pcnt_q == '0) begin
      if (core.start) begin  // Load operands.
        divisor_d = core.divisor;
        dqr_d     = {1'b0, {DATA_W{1'b0}}, core.dividend};
      end else begin
        pcnt_d = pcnt_q;  // Wait.
      end
    end else if (pcnt_q == LAST_STAGE) begin
      pcnt_d = '0;  // Result final, back to idle.
    end else begin
      // One quotient bit per stage.
      if (!diff[DATA_W]) begin
        dqr_d = {diff, dqr_q[DATA_W-2:0], 1'b1};  // Fits, keep difference.
      end else begin
        dqr_d = {1'b0, dqr_q[2*DATA_W-2:0], 1'b0};  // Borrow, keep old value.
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/div_unit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module div_unit_top
  import div_pkg::*;
(
  input  wire logic  clk_i,
  input  wire logic  cke_i,
  input  wire logic  rst_i,
  input  wire logic  start_i,
  input  wire logic  signed_i,
  input  wire data_t dividend_i,
  input  wire data_t divisor_i,
  output logic       done_o,
  output data_t      quotient_o,
  output data_t      remainder_o,
  output logic       div_by_zero_o
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sign stage to core link
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  div_core_if core_if ();

  assign done_o = core_if.done;  // Idle flag of the core.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instances
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  div_sign_stage div_sign_stage_i (
    .clk_i         (clk_i),
    .cke_i         (cke_i),
    .rst_i         (rst_i),
    .start_i       (start_i),
    .signed_i      (signed_i),
    .dividend_i    (dividend_i),
    .divisor_i     (divisor_i),
    .quotient_o    (quotient_o),
    .remainder_o   (remainder_o),
    .div_by_zero_o (div_by_zero_o),
    .core          (core_if.sign_mp)
  );

  div_subshift div_subshift_i (
    .clk_i (clk_i),
    .cke_i (cke_i),
    .rst_i (rst_i),
    .core  (core_if.core_mp)
  );

endmodule

`default_nettype wire

/* testbench/div_ref_model.svh */
`ifndef DIV_REF_MODEL_SVH
`define DIV_REF_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of the divide unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Quotient truncated toward zero, all ones for a zero divisor.
function automatic data_t expected_quotient(input data_t a, input data_t b,
                                            input logic is_signed);
  longint sa;
  longint sb;
  if (b == '0) begin
    return '1;
  end
  if (is_signed) begin
    sa = longint'($signed(a));  // Wide enough for the most negative value over -1.
    sb = longint'($signed(b));
    return data_t'(sa / sb);
  end
  return a / b;
endfunction

// Remainder takes the sign of the dividend, dividend for a zero divisor.
function automatic data_t expected_remainder(input data_t a, input data_t b,
                                             input logic is_signed);
  longint sa;
  longint sb;
  if (b == '0) begin
    return a;
  end
  if (is_signed) begin
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    return data_t'(sa % sb);
  end
  return a % b;
endfunction

function automatic logic expected_div_by_zero(input data_t b);
  return (b == '0);
endfunction

`endif

/* testbench/tb_div_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_div_unit
  import div_pkg::*;
();

  `include "div_ref_model.svh"

  localparam int    NUM_OPS        = 400;
  localparam int    TIMEOUT_CYCLES = NUM_OPS * (DATA_W + 8) * 2;
  localparam data_t MIN_VALUE      = data_t'(1) << (DATA_W - 1);  // Most negative value.

  logic  clk;
  logic  rst;
  logic  cke;
  logic  start;
  logic  sgn;
  data_t dividend;
  data_t divisor;
  logic  done;
  data_t quotient;
  data_t remainder;
  logic  div_by_zero;

  int value_errors = 0;
  int other_errors = 0;
  int cycle_count  = 0;

  div_unit_top div_unit_top_i (
    .clk_i         (clk),
    .cke_i         (cke),
    .rst_i         (rst),
    .start_i       (start),
    .signed_i      (sgn),
    .dividend_i    (dividend),
    .divisor_i     (divisor),
    .done_o        (done),
    .quotient_o    (quotient),
    .remainder_o   (remainder),
    .div_by_zero_o (div_by_zero)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;  // 4 ns period.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reporting
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_data(input string name, input data_t actual, input data_t expected);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s expected 0x%h, actual 0x%h",
               $time, name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s expected %b, actual %b", $time, name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic report_problem(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    other_errors++;
  endtask

  task automatic print_summary();
    $display("Summary: %0d wrong values, %0d other errors", value_errors, other_errors);
  endtask

  // Run limit.
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      report_problem("simulation ran past its cycle limit, the unit seems stuck");
      print_summary();
      $display("Test failed");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic pick_operands(output data_t a, output data_t b, output logic s);
    int kind;
    kind = int'($urandom_range(0, 9));
    a    = $urandom();
    b    = $urandom() >> $urandom_range(0, DATA_W - 1);  // Spread of divisor sizes.
    s    = ($urandom_range(0, 1) == 1);
    case (kind)
      0: b = '0;
      1: b = '1;  // Minus one when signed.
      2: a = MIN_VALUE;
      3: begin
        a = MIN_VALUE;  // Overflow corner.
        b = '1;
        s = 1'b1;
      end
      4: b = data_t'($urandom_range(1, 15));
      default: ;
    endcase
  endtask

  // Idle cycles with changing inputs; results must hold.
  task automatic hold_idle(input data_t exp_q, input data_t exp_r, input logic exp_dz,
                           input int min_n);
    int n;
    n = int'($urandom_range(min_n, 3));
    repeat (n) begin
      @(negedge clk);
      start = 1'b0;
      check_flag("done_o", done, 1'b1);
      check_data("quotient_o", quotient, exp_q);
      check_data("remainder_o", remainder, exp_r);
      check_flag("div_by_zero_o", div_by_zero, exp_dz);
      dividend = $urandom();
      divisor  = $urandom();
      sgn      = ($urandom_range(0, 1) == 1);
    end
  endtask

  task automatic run_operation(input data_t a, input data_t b, input logic s,
                               input logic drop_cke, input logic poke_start);
    data_t exp_q;
    data_t exp_r;
    logic  exp_dz;
    int    edges;
    int    poke_at;
    logic  dropped;
    logic  finished;
    exp_q    = expected_quotient(a, b, s);
    exp_r    = expected_remainder(a, b, s);
    exp_dz   = expected_div_by_zero(b);
    edges    = 1;  // The accepting edge counts as the first.
    dropped  = 1'b0;
    finished = 1'b0;
    poke_at  = -1;
    if (poke_start) begin
      poke_at = int'($urandom_range(1, DATA_W - 2));
    end

    @(negedge clk);
    if (!done) begin
      report_problem("unit was still busy when a new operation was due");
    end
    start    = 1'b1;
    sgn      = s;
    dividend = a;
    divisor  = b;
    cke      = 1'b1;
    @(posedge clk);  // Accepting edge.

    while (!finished) begin
      @(negedge clk);
      start = 1'b0;
      cke   = 1'b1;
      if (done) begin
        finished = 1'b1;
      end else begin
        dividend = $urandom();  // Operands are held inside once accepted.
        divisor  = $urandom();
        if (drop_cke && !dropped && $urandom_range(0, 5) == 0) begin
          cke = 1'b0;  // Single-cycle stall.
        end
        dropped = !cke;
        if (edges == poke_at) begin
          start   = 1'b1;  // Busy start, must be ignored.
          sgn     = ($urandom_range(0, 1) == 1);
          poke_at = -1;
        end
        @(posedge clk);
        if (cke) begin
          edges++;
        end
      end
    end

    if (edges != DATA_W + 1) begin
      report_problem($sformatf("done_o rose after %0d enabled edges instead of %0d",
                               edges, DATA_W + 1));
    end
    check_data("quotient_o", quotient, exp_q);
    check_data("remainder_o", remainder, exp_r);
    check_flag("div_by_zero_o", div_by_zero, exp_dz);
    if (poke_start) begin
      start    = 1'b1;  // Start on the final count, must be ignored.
      sgn      = ($urandom_range(0, 1) == 1);
      dividend = $urandom();
      divisor  = '0;  // Would raise div_by_zero_o if taken.
    end
    hold_idle(exp_q, exp_r, exp_dz, poke_start ? 1 : 0);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Main sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    int    i;
    data_t a;
    data_t b;
    logic  s;
    logic  drop_cke;
    logic  poke;
    void'($urandom(91));
    rst      = 1'b1;
    cke      = 1'b1;
    start    = 1'b0;
    sgn      = 1'b0;
    dividend = '0;
    divisor  = '0;

    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    @(negedge clk);  // Idle state after reset.
    check_flag("done_o", done, 1'b1);
    check_flag("div_by_zero_o", div_by_zero, 1'b0);
    check_data("quotient_o", quotient, '0);
    check_data("remainder_o", remainder, '0);

    for (i = 0; i < NUM_OPS; i++) begin
      pick_operands(a, b, s);
      drop_cke = ($urandom_range(0, 2) == 0);
      poke     = ($urandom_range(0, 3) == 0);
      run_operation(a, b, s, drop_cke, poke);
    end

    print_summary();
    if (value_errors == 0 && other_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
